// File: hw/xcvr_ctrl_pkg.sv
// transceiver control definitions
package xcvr_ctrl_pkg;

   ////////////////////
   // lane and pll counts
   localparam int LANES      = 4;
   localparam int PLLS       = 2;
   localparam int PLL_SELECT = 0;   // pll that gates the tx path

   typedef logic [LANES-1:0] lane_vec_t;
   typedef logic [PLLS-1:0]  pll_vec_t;

   ////////////////////
   // status returned by the transceiver, one bit per lane
   typedef struct packed {
      lane_vec_t locked_to_data;
      lane_vec_t locked_to_ref;
      lane_vec_t tx_cal_busy;
      lane_vec_t rx_cal_busy;
   } lane_status_t;

   ////////////////////
   // reset timer lengths in clk cycles, shortened for simulation
   localparam int PLL_PDN_CYCLES = 16;
   localparam int TX_DIG_CYCLES  = 4;
   localparam int RX_ANA_CYCLES  = 8;
   localparam int RX_DIG_CYCLES  = 32;

   // one width covers all timers, the rx digital wait is the longest
   localparam int TMR_W = $clog2(RX_DIG_CYCLES + 1);

   typedef logic [TMR_W-1:0] tmr_t;

   // flops in each status synchronizer
   localparam int SYNC_STAGES = 2;

endpackage

// File: hw/xcvr_csr_pkg.sv
// management register map
package xcvr_csr_pkg;

   ////////////////////
   // bus widths
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] mgmt_addr_t;
   typedef logic [DATA_W-1:0] mgmt_data_t;

   ////////////////////
   // word addresses
   localparam mgmt_addr_t REG_PLL_LOCKED     = 8'h00;   // ro
   localparam mgmt_addr_t REG_STATUS         = 8'h01;   // ro
   localparam mgmt_addr_t REG_RESET_CTRL     = 8'h02;
   localparam mgmt_addr_t REG_PLL_POWERDOWN  = 8'h03;
   localparam mgmt_addr_t REG_TX_DIGRST      = 8'h04;   // lane mask
   localparam mgmt_addr_t REG_RX_ANARST      = 8'h05;   // lane mask
   localparam mgmt_addr_t REG_RX_DIGRST      = 8'h06;   // lane mask
   localparam mgmt_addr_t REG_LOOPBACK       = 8'h07;   // lane mask
   localparam mgmt_addr_t REG_SET_LOCKTOREF  = 8'h08;   // lane mask
   localparam mgmt_addr_t REG_SET_LOCKTODATA = 8'h09;   // lane mask
   localparam mgmt_addr_t REG_LOCKEDTODATA   = 8'h0A;   // ro
   localparam mgmt_addr_t REG_LOCKEDTOREF    = 8'h0B;   // ro

   ////////////////////
   // REG_STATUS bits
   localparam int STS_TX_READY_BIT = 0;
   localparam int STS_RX_READY_BIT = 1;
   localparam int STS_PLL_PDN_BIT  = 2;

   // REG_RESET_CTRL bits
   localparam int RST_ALL_BIT = 0;   // write only, reads back zero
   localparam int RST_TX_BIT  = 1;   // tx digital hold
   localparam int RST_RX_BIT  = 2;   // rx digital hold

endpackage

// File: hw/xcvr_seq_if.sv
// register map to reset sequencer link
`timescale 1ns/1ps

interface xcvr_seq_if;

   // requests from the register map
   logic reset_all_req;       // single-cycle strobe
   logic tx_digital_req;      // level
   logic rx_digital_req;      // level
   logic rx_manual;           // some lane has a forced lock mode
   logic pll_powerdown_req;   // register bit, holds the timers at restart

   // sequencer state
   logic seq_pll_powerdown;
   logic seq_tx_digitalreset;
   logic seq_rx_analogreset;
   logic seq_rx_digitalreset;
   logic tx_ready;
   logic rx_ready;

   modport csr (
      output reset_all_req, tx_digital_req, rx_digital_req, rx_manual,
      output pll_powerdown_req,
      input  seq_pll_powerdown, seq_tx_digitalreset, seq_rx_analogreset,
      input  seq_rx_digitalreset, tx_ready, rx_ready
   );

   modport seq (
      input  reset_all_req, tx_digital_req, rx_digital_req, rx_manual,
      input  pll_powerdown_req,
      output seq_pll_powerdown, seq_tx_digitalreset, seq_rx_analogreset,
      output seq_rx_digitalreset, tx_ready, rx_ready
   );

endinterface

// File: hw/status_sync.sv
// status synchronizer
`timescale 1ns/1ps

module status_sync #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     embedded_reset,
   input  payload_t async_in,
   output payload_t sync_out
);

   payload_t sync_q [xcvr_ctrl_pkg::SYNC_STAGES];

   always_ff @(posedge clk)
   begin
      if (embedded_reset)
      begin
         for (int i = 0; i < xcvr_ctrl_pkg::SYNC_STAGES; i++)
            sync_q[i] <= '0;
      end
      else
      begin
         sync_q[0] <= async_in;   // first stage may go metastable
         for (int i = 1; i < xcvr_ctrl_pkg::SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
      end
   end

   assign sync_out = sync_q[xcvr_ctrl_pkg::SYNC_STAGES-1];

endmodule

// File: hw/xcvr_mgmt_csr.sv
// management registers and reset merge
`timescale 1ns/1ps

module xcvr_mgmt_csr (
   input  logic                        clk,
   input  logic                        embedded_reset,
   input  xcvr_csr_pkg::mgmt_addr_t    mgmt_address,
   input  logic                        mgmt_read,
   input  logic                        mgmt_write,
   input  xcvr_csr_pkg::mgmt_data_t    mgmt_writedata,
   output xcvr_csr_pkg::mgmt_data_t    mgmt_readdata,
   output logic                        mgmt_waitrequest,
   input  xcvr_ctrl_pkg::lane_status_t status,
   input  xcvr_ctrl_pkg::pll_vec_t     pll_status,
   xcvr_seq_if.csr                     seq,
   output xcvr_ctrl_pkg::pll_vec_t     pll_powerdown,
   output xcvr_ctrl_pkg::lane_vec_t    tx_digitalreset,
   output xcvr_ctrl_pkg::lane_vec_t    rx_analogreset,
   output xcvr_ctrl_pkg::lane_vec_t    rx_digitalreset,
   output xcvr_ctrl_pkg::lane_vec_t    rx_seriallpbken,
   output xcvr_ctrl_pkg::lane_vec_t    rx_set_locktodata,
   output xcvr_ctrl_pkg::lane_vec_t    rx_set_locktoref
);

   logic                     pll_pdn_q;
   logic                     tx_hold_q;
   logic                     rx_hold_q;
   xcvr_ctrl_pkg::lane_vec_t tx_digrst_q;
   xcvr_ctrl_pkg::lane_vec_t rx_anarst_q;
   xcvr_ctrl_pkg::lane_vec_t rx_digrst_q;
   xcvr_ctrl_pkg::lane_vec_t loopback_q;
   xcvr_ctrl_pkg::lane_vec_t locktoref_q;
   xcvr_ctrl_pkg::lane_vec_t locktodata_q;
   xcvr_ctrl_pkg::lane_vec_t wr_mask;
   logic                     rd_done_q;   // second cycle of a read
   xcvr_csr_pkg::mgmt_data_t rd_mux;
   xcvr_csr_pkg::mgmt_data_t readdata_q;

   assign wr_mask = mgmt_writedata[xcvr_ctrl_pkg::LANES-1:0];

   ////////////////////
   // register writes
   always_ff @(posedge clk)
   begin
      if (embedded_reset)
      begin
         pll_pdn_q    <= 1'b0;
         tx_hold_q    <= 1'b0;
         rx_hold_q    <= 1'b0;
         tx_digrst_q  <= '0;
         rx_anarst_q  <= '0;
         rx_digrst_q  <= '0;
         loopback_q   <= '0;
         locktoref_q  <= '0;
         locktodata_q <= '0;
      end
      else if (mgmt_write)
      begin
         case (mgmt_address)
            xcvr_csr_pkg::REG_RESET_CTRL:
            begin
               tx_hold_q <= mgmt_writedata[xcvr_csr_pkg::RST_TX_BIT];
               rx_hold_q <= mgmt_writedata[xcvr_csr_pkg::RST_RX_BIT];
            end
            xcvr_csr_pkg::REG_PLL_POWERDOWN:  pll_pdn_q    <= mgmt_writedata[0];
            xcvr_csr_pkg::REG_TX_DIGRST:      tx_digrst_q  <= wr_mask;
            xcvr_csr_pkg::REG_RX_ANARST:      rx_anarst_q  <= wr_mask;
            xcvr_csr_pkg::REG_RX_DIGRST:      rx_digrst_q  <= wr_mask;
            xcvr_csr_pkg::REG_LOOPBACK:       loopback_q   <= wr_mask;
            xcvr_csr_pkg::REG_SET_LOCKTOREF:  locktoref_q  <= wr_mask;
            xcvr_csr_pkg::REG_SET_LOCKTODATA: locktodata_q <= wr_mask;
            default: ;   // read-only and unmapped words
         endcase
      end
   end

   // reset_all acts on the write edge itself
   assign seq.reset_all_req = mgmt_write
                              && (mgmt_address == xcvr_csr_pkg::REG_RESET_CTRL)
                              && mgmt_writedata[xcvr_csr_pkg::RST_ALL_BIT];
   assign seq.tx_digital_req    = tx_hold_q;
   assign seq.rx_digital_req    = rx_hold_q;
   assign seq.pll_powerdown_req = pll_pdn_q;
   assign seq.rx_manual         = |(locktoref_q | locktodata_q);

   ////////////////////
   // read mux
   always_comb
   begin
      rd_mux = '0;   // unmapped words read zero
      case (mgmt_address)
         xcvr_csr_pkg::REG_PLL_LOCKED:
            rd_mux[xcvr_ctrl_pkg::PLLS-1:0] = pll_status;
         xcvr_csr_pkg::REG_STATUS:
         begin
            rd_mux[xcvr_csr_pkg::STS_TX_READY_BIT] = seq.tx_ready;
            rd_mux[xcvr_csr_pkg::STS_RX_READY_BIT] = seq.rx_ready;
            rd_mux[xcvr_csr_pkg::STS_PLL_PDN_BIT]  = seq.seq_pll_powerdown | pll_pdn_q;
         end
         xcvr_csr_pkg::REG_RESET_CTRL:
         begin
            rd_mux[xcvr_csr_pkg::RST_TX_BIT] = tx_hold_q;
            rd_mux[xcvr_csr_pkg::RST_RX_BIT] = rx_hold_q;
         end
         xcvr_csr_pkg::REG_PLL_POWERDOWN:  rd_mux[0] = pll_pdn_q;
         xcvr_csr_pkg::REG_TX_DIGRST:      rd_mux[xcvr_ctrl_pkg::LANES-1:0] = tx_digrst_q;
         xcvr_csr_pkg::REG_RX_ANARST:      rd_mux[xcvr_ctrl_pkg::LANES-1:0] = rx_anarst_q;
         xcvr_csr_pkg::REG_RX_DIGRST:      rd_mux[xcvr_ctrl_pkg::LANES-1:0] = rx_digrst_q;
         xcvr_csr_pkg::REG_LOOPBACK:       rd_mux[xcvr_ctrl_pkg::LANES-1:0] = loopback_q;
         xcvr_csr_pkg::REG_SET_LOCKTOREF:  rd_mux[xcvr_ctrl_pkg::LANES-1:0] = locktoref_q;
         xcvr_csr_pkg::REG_SET_LOCKTODATA: rd_mux[xcvr_ctrl_pkg::LANES-1:0] = locktodata_q;
         xcvr_csr_pkg::REG_LOCKEDTODATA:
            rd_mux[xcvr_ctrl_pkg::LANES-1:0] = status.locked_to_data;
         xcvr_csr_pkg::REG_LOCKEDTOREF:
            rd_mux[xcvr_ctrl_pkg::LANES-1:0] = status.locked_to_ref;
         default: ;
      endcase
   end

   ////////////////////
   // read wait generator, one wait cycle per read
   always_ff @(posedge clk)
   begin
      if (embedded_reset)
         rd_done_q <= 1'b0;
      else
         rd_done_q <= mgmt_read && !rd_done_q;
   end

   always_ff @(posedge clk)
   begin
      if (mgmt_read && !rd_done_q)
         readdata_q <= rd_mux;   // sampled in the wait cycle
   end

   assign mgmt_readdata    = readdata_q;
   assign mgmt_waitrequest = mgmt_read && !rd_done_q;

   ////////////////////
   // manual overrides merged with the sequencer
   assign pll_powerdown   = {xcvr_ctrl_pkg::PLLS{seq.seq_pll_powerdown | pll_pdn_q}};
   assign tx_digitalreset = {xcvr_ctrl_pkg::LANES{seq.seq_tx_digitalreset}} | tx_digrst_q;
   assign rx_analogreset  = {xcvr_ctrl_pkg::LANES{seq.seq_rx_analogreset}} | rx_anarst_q;
   assign rx_digitalreset = {xcvr_ctrl_pkg::LANES{seq.seq_rx_digitalreset}} | rx_digrst_q;

   assign rx_seriallpbken   = loopback_q;
   assign rx_set_locktodata = locktodata_q;
   assign rx_set_locktoref  = locktoref_q;

endmodule

// File: hw/xcvr_reset_seq.sv
// embedded reset sequencer
`timescale 1ns/1ps

module xcvr_reset_seq (
   input  logic                        clk,
   input  logic                        embedded_reset,
   input  xcvr_ctrl_pkg::lane_status_t status,
   input  xcvr_ctrl_pkg::pll_vec_t     pll_status,
   xcvr_seq_if.seq                     ctl
);

   typedef enum logic [1:0] {TX_WAIT, TX_COUNT, TX_DONE} tx_state_t;
   typedef enum logic [1:0] {RX_ANALOG, RX_LOCK, RX_DONE} rx_state_t;

   logic                pdn_q;
   xcvr_ctrl_pkg::tmr_t pdn_cnt;
   tx_state_t           tx_state;
   xcvr_ctrl_pkg::tmr_t tx_cnt;
   rx_state_t           rx_state;
   xcvr_ctrl_pkg::tmr_t rx_cnt;
   logic                restart;
   logic                tx_start;   // pll locked and calibration done
   logic                tx_lost;
   logic                all_locked;

   assign restart  = ctl.reset_all_req || ctl.pll_powerdown_req;
   assign tx_start = pll_status[xcvr_ctrl_pkg::PLL_SELECT]
                     && !(|status.tx_cal_busy) && !ctl.tx_digital_req;
   assign tx_lost  = !pll_status[xcvr_ctrl_pkg::PLL_SELECT] || ctl.tx_digital_req;
   assign all_locked = &status.locked_to_data;

   ////////////////////
   // pll powerdown timer
   always_ff @(posedge clk)
   begin
      if (embedded_reset || restart)
      begin
         pdn_q   <= 1'b1;
         pdn_cnt <= '0;
      end
      else if (pdn_q)
      begin
         if (pdn_cnt == xcvr_ctrl_pkg::tmr_t'(xcvr_ctrl_pkg::PLL_PDN_CYCLES - 1))
            pdn_q <= 1'b0;
         pdn_cnt <= pdn_cnt + 1'b1;
      end
   end

   ////////////////////
   // tx path
   always_ff @(posedge clk)
   begin
      if (embedded_reset || restart || pdn_q)
      begin
         tx_state <= TX_WAIT;
         tx_cnt   <= '0;
      end
      else
      begin
         case (tx_state)
            TX_WAIT:
            begin
               tx_cnt <= '0;
               if (tx_start)
                  tx_state <= TX_COUNT;
            end
            TX_COUNT:
            begin
               if (tx_lost)
                  tx_state <= TX_WAIT;
               else if (tx_cnt == xcvr_ctrl_pkg::tmr_t'(xcvr_ctrl_pkg::TX_DIG_CYCLES - 1))
                  tx_state <= TX_DONE;
               else
                  tx_cnt <= tx_cnt + 1'b1;
            end
            TX_DONE:
            begin
               if (tx_lost)
                  tx_state <= TX_WAIT;   // pll dropped or digital hold
            end
            default: tx_state <= TX_WAIT;
         endcase
      end
   end

   ////////////////////
   // rx path, every lane shares one sequence
   always_ff @(posedge clk)
   begin
      if (embedded_reset || restart || pdn_q)
      begin
         rx_state <= RX_ANALOG;
         rx_cnt   <= '0;
      end
      else
      begin
         case (rx_state)
            RX_ANALOG:
            begin
               if (rx_cnt != xcvr_ctrl_pkg::tmr_t'(xcvr_ctrl_pkg::RX_ANA_CYCLES - 1))
                  rx_cnt <= rx_cnt + 1'b1;
               else if (!(|status.rx_cal_busy))
               begin
                  rx_state <= RX_LOCK;
                  rx_cnt   <= '0;
               end
            end
            RX_LOCK:
            begin
               // lock must hold for the whole window
               if (!all_locked || ctl.rx_digital_req)
                  rx_cnt <= '0;
               else if (rx_cnt == xcvr_ctrl_pkg::tmr_t'(xcvr_ctrl_pkg::RX_DIG_CYCLES - 1))
                  rx_state <= RX_DONE;
               else
                  rx_cnt <= rx_cnt + 1'b1;
            end
            RX_DONE:
            begin
               if (ctl.rx_digital_req || (!ctl.rx_manual && !all_locked))
               begin
                  rx_state <= RX_LOCK;
                  rx_cnt   <= '0;
               end
            end
            default: rx_state <= RX_ANALOG;
         endcase
      end
   end

   assign ctl.seq_pll_powerdown   = pdn_q;
   assign ctl.seq_tx_digitalreset = (tx_state != TX_DONE);
   assign ctl.tx_ready            = (tx_state == TX_DONE);
   assign ctl.seq_rx_analogreset  = (rx_state == RX_ANALOG);
   assign ctl.seq_rx_digitalreset = (rx_state != RX_DONE);
   assign ctl.rx_ready            = (rx_state == RX_DONE);

endmodule

// File: hw/xcvr_ctrl_top.sv
// transceiver management and reset top
`timescale 1ns/1ps

module xcvr_ctrl_top (
   input  logic                     clk,
   input  logic                     embedded_reset,
   // management port
   input  xcvr_csr_pkg::mgmt_addr_t mgmt_address,
   input  logic                     mgmt_read,
   input  logic                     mgmt_write,
   input  xcvr_csr_pkg::mgmt_data_t mgmt_writedata,
   output xcvr_csr_pkg::mgmt_data_t mgmt_readdata,
   output logic                     mgmt_waitrequest,
   // status from the transceiver
   input  xcvr_ctrl_pkg::pll_vec_t  pll_locked,
   input  xcvr_ctrl_pkg::lane_vec_t rx_is_lockedtodata,
   input  xcvr_ctrl_pkg::lane_vec_t rx_is_lockedtoref,
   input  xcvr_ctrl_pkg::lane_vec_t tx_cal_busy,
   input  xcvr_ctrl_pkg::lane_vec_t rx_cal_busy,
   // resets and controls to the transceiver
   output xcvr_ctrl_pkg::pll_vec_t  pll_powerdown,
   output xcvr_ctrl_pkg::lane_vec_t tx_analogreset,
   output xcvr_ctrl_pkg::lane_vec_t tx_digitalreset,
   output xcvr_ctrl_pkg::lane_vec_t rx_analogreset,
   output xcvr_ctrl_pkg::lane_vec_t rx_digitalreset,
   output xcvr_ctrl_pkg::lane_vec_t rx_seriallpbken,
   output xcvr_ctrl_pkg::lane_vec_t rx_set_locktodata,
   output xcvr_ctrl_pkg::lane_vec_t rx_set_locktoref,
   output logic                     tx_pma_ready,
   output logic                     rx_pma_ready
);

   xcvr_ctrl_pkg::lane_status_t status_raw;
   xcvr_ctrl_pkg::lane_status_t status_s;
   xcvr_ctrl_pkg::pll_vec_t     pll_locked_s;

   xcvr_seq_if seq_if ();

   assign status_raw.locked_to_data = rx_is_lockedtodata;
   assign status_raw.locked_to_ref  = rx_is_lockedtoref;
   assign status_raw.tx_cal_busy    = tx_cal_busy;
   assign status_raw.rx_cal_busy    = rx_cal_busy;

   ////////////////////
   // status into the clk domain
   status_sync #(.payload_t(xcvr_ctrl_pkg::lane_status_t)) lane_sync (
      .clk            (clk),
      .embedded_reset (embedded_reset),
      .async_in       (status_raw),
      .sync_out       (status_s)
   );

   status_sync #(.payload_t(xcvr_ctrl_pkg::pll_vec_t)) pll_sync (
      .clk            (clk),
      .embedded_reset (embedded_reset),
      .async_in       (pll_locked),
      .sync_out       (pll_locked_s)
   );

   xcvr_mgmt_csr csr (
      .clk               (clk),
      .embedded_reset    (embedded_reset),
      .mgmt_address      (mgmt_address),
      .mgmt_read         (mgmt_read),
      .mgmt_write        (mgmt_write),
      .mgmt_writedata    (mgmt_writedata),
      .mgmt_readdata     (mgmt_readdata),
      .mgmt_waitrequest  (mgmt_waitrequest),
      .status            (status_s),
      .pll_status        (pll_locked_s),
      .seq               (seq_if.csr),
      .pll_powerdown     (pll_powerdown),
      .tx_digitalreset   (tx_digitalreset),
      .rx_analogreset    (rx_analogreset),
      .rx_digitalreset   (rx_digitalreset),
      .rx_seriallpbken   (rx_seriallpbken),
      .rx_set_locktodata (rx_set_locktodata),
      .rx_set_locktoref  (rx_set_locktoref)
   );

   xcvr_reset_seq reset_seq (
      .clk            (clk),
      .embedded_reset (embedded_reset),
      .status         (status_s),
      .pll_status     (pll_locked_s),
      .ctl            (seq_if.seq)
   );

   // tx pma held in reset while the pll is powered down
   assign tx_analogreset = {xcvr_ctrl_pkg::LANES{pll_powerdown[xcvr_ctrl_pkg::PLL_SELECT]}};

   assign tx_pma_ready = seq_if.tx_ready;
   assign rx_pma_ready = seq_if.rx_ready;

endmodule

// File: bench/xcvr_ctrl_tb.sv
// transceiver control testbench
`timescale 1ns/1ps

module xcvr_ctrl_tb;

   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 5;
   localparam int SEED            = 86708;
   localparam int WATCHDOG_CYCLES = 3000;   // test budgets summed, with margin
   localparam int TX_LIMIT        = 2 + xcvr_ctrl_pkg::TX_DIG_CYCLES + 2;
   localparam int RX_LIMIT        = 2 + xcvr_ctrl_pkg::RX_DIG_CYCLES + 2;
   localparam int LOSS_LIMIT      = 4;      // sync latency plus one state change

   localparam xcvr_ctrl_pkg::lane_vec_t ALL_LANES = '1;
   localparam xcvr_ctrl_pkg::pll_vec_t  ALL_PLLS  = '1;
   localparam xcvr_csr_pkg::mgmt_data_t LANE_MASK =
      {{(xcvr_csr_pkg::DATA_W - xcvr_ctrl_pkg::LANES){1'b0}}, ALL_LANES};

   logic                     clk;
   logic                     embedded_reset;
   xcvr_csr_pkg::mgmt_addr_t mgmt_address;
   logic                     mgmt_read;
   logic                     mgmt_write;
   xcvr_csr_pkg::mgmt_data_t mgmt_writedata;
   xcvr_csr_pkg::mgmt_data_t mgmt_readdata;
   logic                     mgmt_waitrequest;
   xcvr_ctrl_pkg::pll_vec_t  pll_locked;
   xcvr_ctrl_pkg::lane_vec_t rx_is_lockedtodata;
   xcvr_ctrl_pkg::lane_vec_t rx_is_lockedtoref;
   xcvr_ctrl_pkg::lane_vec_t tx_cal_busy;
   xcvr_ctrl_pkg::lane_vec_t rx_cal_busy;
   xcvr_ctrl_pkg::pll_vec_t  pll_powerdown;
   xcvr_ctrl_pkg::lane_vec_t tx_analogreset;
   xcvr_ctrl_pkg::lane_vec_t tx_digitalreset;
   xcvr_ctrl_pkg::lane_vec_t rx_analogreset;
   xcvr_ctrl_pkg::lane_vec_t rx_digitalreset;
   xcvr_ctrl_pkg::lane_vec_t rx_seriallpbken;
   xcvr_ctrl_pkg::lane_vec_t rx_set_locktodata;
   xcvr_ctrl_pkg::lane_vec_t rx_set_locktoref;
   logic                     tx_pma_ready;
   logic                     rx_pma_ready;

   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;

   xcvr_ctrl_top UUT (
      .clk                (clk),
      .embedded_reset     (embedded_reset),
      .mgmt_address       (mgmt_address),
      .mgmt_read          (mgmt_read),
      .mgmt_write         (mgmt_write),
      .mgmt_writedata     (mgmt_writedata),
      .mgmt_readdata      (mgmt_readdata),
      .mgmt_waitrequest   (mgmt_waitrequest),
      .pll_locked         (pll_locked),
      .rx_is_lockedtodata (rx_is_lockedtodata),
      .rx_is_lockedtoref  (rx_is_lockedtoref),
      .tx_cal_busy        (tx_cal_busy),
      .rx_cal_busy        (rx_cal_busy),
      .pll_powerdown      (pll_powerdown),
      .tx_analogreset     (tx_analogreset),
      .tx_digitalreset    (tx_digitalreset),
      .rx_analogreset     (rx_analogreset),
      .rx_digitalreset    (rx_digitalreset),
      .rx_seriallpbken    (rx_seriallpbken),
      .rx_set_locktodata  (rx_set_locktodata),
      .rx_set_locktoref   (rx_set_locktoref),
      .tx_pma_ready       (tx_pma_ready),
      .rx_pma_ready       (rx_pma_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   ////////////////////
   // checking helpers
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
      end
   endtask

   task automatic write_reg(input xcvr_csr_pkg::mgmt_addr_t addr,
                            input xcvr_csr_pkg::mgmt_data_t data);
      @(negedge clk);
      mgmt_address   = addr;
      mgmt_writedata = data;
      mgmt_write     = 1'b1;
      @(negedge clk);
      mgmt_write = 1'b0;
   endtask

   // read held two cycles, waitrequest in the first only
   task automatic read_check(input xcvr_csr_pkg::mgmt_addr_t addr,
                             input xcvr_csr_pkg::mgmt_data_t exp);
      @(negedge clk);
      mgmt_address = addr;
      mgmt_read    = 1'b1;
      #(CLK_PERIOD/4);   // let the combinational wait settle
      check_value("mgmt_waitrequest", mgmt_waitrequest, 1'b1);
      @(negedge clk);
      check_value("mgmt_waitrequest", mgmt_waitrequest, 1'b0);
      check_value($sformatf("mgmt_readdata at 0x%02h", addr), mgmt_readdata, exp);
      @(negedge clk);
      mgmt_read = 1'b0;
   endtask

   task automatic wait_for_ready(input bit rx_side, input logic level, input int limit);
      int   n;
      logic now_val;
      n       = 0;
      now_val = rx_side ? rx_pma_ready : tx_pma_ready;
      while (now_val !== level && n < limit)
      begin
         @(negedge clk);
         n++;
         now_val = rx_side ? rx_pma_ready : tx_pma_ready;
      end
      assert (now_val === level)
      else
      begin
         errors++;
         $display("%s did not go to %0b within %0d cycles",
                  rx_side ? "rx_pma_ready" : "tx_pma_ready", level, limit);
      end
   endtask

   // starts on the falling edge right after the restart edge
   task automatic check_powerdown();
      check_value("pll_powerdown", pll_powerdown, ALL_PLLS);
      check_value("tx_analogreset", tx_analogreset, ALL_LANES);
      repeat (xcvr_ctrl_pkg::PLL_PDN_CYCLES - 1)
      begin
         @(negedge clk);
         check_value("pll_powerdown", pll_powerdown, ALL_PLLS);
         check_value("tx_analogreset", tx_analogreset, ALL_LANES);
      end
      @(negedge clk);
      check_value("pll_powerdown", pll_powerdown, '0);
      check_value("tx_analogreset", tx_analogreset, '0);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %0d %s: pass", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: fail, %0d errors", tests_run, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   ////////////////////
   // invariants, a quarter period after each rising edge
   always @(posedge clk)
   begin
      #(CLK_PERIOD/4);
      if (!mgmt_read)
         check_value("mgmt_waitrequest", mgmt_waitrequest, 1'b0);   // no read, no wait
   end

   ////////////////////
   // stimulus
   initial
   begin : stimulus
      xcvr_csr_pkg::mgmt_data_t rnd;
      xcvr_csr_pkg::mgmt_addr_t addr;
      xcvr_ctrl_pkg::lane_vec_t lane_val;
      xcvr_ctrl_pkg::lane_vec_t ref_val;
      xcvr_ctrl_pkg::pll_vec_t  pll_val;
      int                       lane;

      errors             = 0;
      errors_at_start    = 0;
      tests_run          = 0;
      tests_failed       = 0;
      void'($urandom(SEED));
      embedded_reset     = 1'b1;
      mgmt_address       = '0;
      mgmt_read          = 1'b0;
      mgmt_write         = 1'b0;
      mgmt_writedata     = '0;
      pll_locked         = '0;
      rx_is_lockedtodata = '0;
      rx_is_lockedtoref  = '0;
      tx_cal_busy        = '0;
      rx_cal_busy        = '0;

      // power-up
      repeat (2) @(negedge clk);
      check_value("pll_powerdown", pll_powerdown, ALL_PLLS);
      check_value("tx_analogreset", tx_analogreset, ALL_LANES);
      check_value("tx_digitalreset", tx_digitalreset, ALL_LANES);
      check_value("rx_analogreset", rx_analogreset, ALL_LANES);
      check_value("rx_digitalreset", rx_digitalreset, ALL_LANES);
      check_value("tx_pma_ready", tx_pma_ready, 1'b0);
      check_value("rx_pma_ready", rx_pma_ready, 1'b0);
      check_value("mgmt_waitrequest", mgmt_waitrequest, 1'b0);
      repeat (RESET_CYCLES - 2) @(negedge clk);
      embedded_reset = 1'b0;
      check_powerdown();
      check_value("tx_pma_ready", tx_pma_ready, 1'b0);
      end_test("power-up");

      // tx sequence
      @(negedge clk);
      pll_locked = ALL_PLLS;
      wait_for_ready(1'b0, 1'b1, TX_LIMIT);
      check_value("tx_digitalreset", tx_digitalreset, '0);
      @(negedge clk);
      pll_locked[xcvr_ctrl_pkg::PLL_SELECT] = 1'b0;
      wait_for_ready(1'b0, 1'b0, LOSS_LIMIT);
      check_value("tx_digitalreset", tx_digitalreset, ALL_LANES);
      @(negedge clk);
      pll_locked = ALL_PLLS;
      wait_for_ready(1'b0, 1'b1, TX_LIMIT);
      end_test("tx sequence");

      // rx sequence, lanes lock one at a time
      check_value("rx_analogreset", rx_analogreset, '0);
      check_value("rx_pma_ready", rx_pma_ready, 1'b0);
      for (int i = 0; i < xcvr_ctrl_pkg::LANES; i++)
      begin
         @(negedge clk);
         rx_is_lockedtodata[i] = 1'b1;
      end
      wait_for_ready(1'b1, 1'b1, RX_LIMIT);
      check_value("rx_digitalreset", rx_digitalreset, '0);
      lane = int'($urandom % xcvr_ctrl_pkg::LANES);
      @(negedge clk);
      rx_is_lockedtodata[lane] = 1'b0;   // auto mode drops ready
      wait_for_ready(1'b1, 1'b0, LOSS_LIMIT);
      check_value("rx_digitalreset", rx_digitalreset, ALL_LANES);
      @(negedge clk);
      rx_is_lockedtodata = ALL_LANES;
      wait_for_ready(1'b1, 1'b1, RX_LIMIT);
      write_reg(xcvr_csr_pkg::REG_SET_LOCKTODATA, LANE_MASK);
      lane = int'($urandom % xcvr_ctrl_pkg::LANES);
      rx_is_lockedtodata[lane] = 1'b0;   // manual mode keeps ready
      repeat (2 * LOSS_LIMIT)
      begin
         @(negedge clk);
         check_value("rx_pma_ready", rx_pma_ready, 1'b1);
      end
      rx_is_lockedtodata = ALL_LANES;
      repeat (LOSS_LIMIT) @(negedge clk);
      write_reg(xcvr_csr_pkg::REG_SET_LOCKTODATA, '0);
      check_value("rx_pma_ready", rx_pma_ready, 1'b1);
      end_test("rx sequence and modes");

      // register access, masks at 0x04 to 0x09
      for (int r = 0; r < 6; r++)
      begin
         addr = xcvr_csr_pkg::mgmt_addr_t'(xcvr_csr_pkg::REG_TX_DIGRST + r);
         rnd  = $urandom;
         write_reg(addr, rnd);
         read_check(addr, rnd & LANE_MASK);
      end
      for (int r = 0; r < 6; r++)
         write_reg(xcvr_csr_pkg::mgmt_addr_t'(xcvr_csr_pkg::REG_TX_DIGRST + r), '0);
      repeat (4)
      begin
         addr = xcvr_csr_pkg::mgmt_addr_t'(xcvr_csr_pkg::REG_LOCKEDTOREF + 1
                + ($urandom % (255 - xcvr_csr_pkg::REG_LOCKEDTOREF)));
         read_check(addr, '0);
      end
      lane_val = xcvr_ctrl_pkg::lane_vec_t'($urandom);
      ref_val  = ~lane_val;
      pll_val  = xcvr_ctrl_pkg::pll_vec_t'($urandom);
      @(negedge clk);
      rx_is_lockedtodata = lane_val;
      rx_is_lockedtoref  = ref_val;
      pll_locked         = pll_val;
      repeat (3) @(negedge clk);
      read_check(xcvr_csr_pkg::REG_LOCKEDTODATA, lane_val);
      read_check(xcvr_csr_pkg::REG_LOCKEDTOREF, ref_val);
      read_check(xcvr_csr_pkg::REG_PLL_LOCKED, pll_val);
      @(negedge clk);
      rx_is_lockedtodata = ALL_LANES;
      rx_is_lockedtoref  = ALL_LANES;
      pll_locked         = ALL_PLLS;
      wait_for_ready(1'b0, 1'b1, TX_LIMIT);
      wait_for_ready(1'b1, 1'b1, RX_LIMIT);
      read_check(xcvr_csr_pkg::REG_STATUS, 32'h3);   // both ready, pll up
      end_test("register access");

      // per-lane overrides on the three reset masks
      for (int r = 0; r < 3; r++)
      begin
         addr = xcvr_csr_pkg::mgmt_addr_t'(xcvr_csr_pkg::REG_TX_DIGRST + r);
         for (int l = 0; l < xcvr_ctrl_pkg::LANES; l++)
         begin
            lane_val = xcvr_ctrl_pkg::lane_vec_t'(1 << l);
            write_reg(addr, lane_val);
            check_value("tx_digitalreset", tx_digitalreset, (r == 0) ? lane_val : '0);
            check_value("rx_analogreset", rx_analogreset, (r == 1) ? lane_val : '0);
            check_value("rx_digitalreset", rx_digitalreset, (r == 2) ? lane_val : '0);
         end
         write_reg(addr, '0);
      end
      rnd = $urandom;
      write_reg(xcvr_csr_pkg::REG_LOOPBACK, rnd);
      check_value("rx_seriallpbken", rx_seriallpbken, rnd & LANE_MASK);
      rnd = $urandom;
      write_reg(xcvr_csr_pkg::REG_SET_LOCKTODATA, rnd);
      check_value("rx_set_locktodata", rx_set_locktodata, rnd & LANE_MASK);
      rnd = $urandom;
      write_reg(xcvr_csr_pkg::REG_SET_LOCKTOREF, rnd);
      check_value("rx_set_locktoref", rx_set_locktoref, rnd & LANE_MASK);
      write_reg(xcvr_csr_pkg::REG_LOOPBACK, '0);
      write_reg(xcvr_csr_pkg::REG_SET_LOCKTODATA, '0);
      write_reg(xcvr_csr_pkg::REG_SET_LOCKTOREF, '0);
      check_value("tx_pma_ready", tx_pma_ready, 1'b1);
      check_value("rx_pma_ready", rx_pma_ready, 1'b1);
      end_test("overrides");

      // restarts
      write_reg(xcvr_csr_pkg::REG_RESET_CTRL,
                xcvr_csr_pkg::mgmt_data_t'(1) << xcvr_csr_pkg::RST_ALL_BIT);
      check_value("tx_pma_ready", tx_pma_ready, 1'b0);
      check_value("rx_pma_ready", rx_pma_ready, 1'b0);
      check_powerdown();
      read_check(xcvr_csr_pkg::REG_RESET_CTRL, '0);   // strobe bit reads zero
      wait_for_ready(1'b0, 1'b1, TX_LIMIT);
      wait_for_ready(1'b1, 1'b1, xcvr_ctrl_pkg::RX_ANA_CYCLES + RX_LIMIT);
      write_reg(xcvr_csr_pkg::REG_RESET_CTRL,
                xcvr_csr_pkg::mgmt_data_t'(1) << xcvr_csr_pkg::RST_TX_BIT);
      wait_for_ready(1'b0, 1'b0, LOSS_LIMIT);
      repeat (3 * TX_LIMIT)
      begin
         @(negedge clk);
         check_value("tx_pma_ready", tx_pma_ready, 1'b0);
      end
      write_reg(xcvr_csr_pkg::REG_RESET_CTRL, '0);
      check_value("tx_pma_ready", tx_pma_ready, 1'b0);
      wait_for_ready(1'b0, 1'b1, TX_LIMIT);
      end_test("restarts");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: vlog.f
hw/xcvr_ctrl_pkg.sv
hw/xcvr_csr_pkg.sv
hw/xcvr_seq_if.sv
hw/status_sync.sv
hw/xcvr_mgmt_csr.sv
hw/xcvr_reset_seq.sv
hw/xcvr_ctrl_top.sv
bench/xcvr_ctrl_tb.sv
